// File: Makefile
# Verilator flow for the array controller.

VERILATOR ?= verilator
FILELIST  ?= array_ctl.f
TB_TOP    ?= tb_array_ctl
RTL_TOP   ?= array_ctl_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST) $(VFLAGS)

sim:
	$(VERILATOR) --binary --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) $(VFLAGS)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: array_ctl.f
design/ctrl_map_pkg.sv
design/ctrl_settings_pkg.sv
design/fetch_if.sv
design/ctl_sequencer.sv
design/settings_loader.sv
design/array_ctl_top.sv
verification/ctrl_ram_model.sv
verification/tb_array_ctl.sv

// File: design/array_ctl_top.sv
`timescale 1ns/1ps
`default_nettype none

module array_ctl_top
    import ctrl_map_pkg::*;
    import ctrl_settings_pkg::*;
(
    input  wire                   CLK,
    input  wire                   rst_n,
    output logic                  we,
    output logic [BUS_ADDR_W-1:0] addr,
    output logic [BUS_DATA_W-1:0] din,
    input  wire  [BUS_DATA_W-1:0] dout,
    input  wire                   thermo,
    input  wire                   stm_segment,
    input  wire                   mod_segment,
    input  wire  [15:0]           stm_cycle,
    output silencer_settings_t    silencer_settings,
    output logic                  silencer_update,
    output sync_settings_t        sync_settings,
    output logic                  sync_update,
    output logic                  force_fan,
    output logic [3:0]            gpio_in
);

    fetch_if fetch_bus ();

    // Polls the control RAM and issues tagged settings reads.
    ctl_sequencer u_ctl_sequencer (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .thermo      (thermo),
        .stm_segment (stm_segment),
        .mod_segment (mod_segment),
        .stm_cycle   (stm_cycle),
        .dout        (dout),
        .we          (we),
        .addr        (addr),
        .din         (din),
        .fetch       (fetch_bus.sequencer),
        .force_fan   (force_fan),
        .gpio_in     (gpio_in)
    );

    // Stores returning words and raises the update strobes.
    settings_loader u_settings_loader (
        .CLK               (CLK),
        .rst_n             (rst_n),
        .dout              (dout),
        .fetch             (fetch_bus.loader),
        .silencer_settings (silencer_settings),
        .silencer_update   (silencer_update),
        .sync_settings     (sync_settings),
        .sync_update       (sync_update)
    );

endmodule

`default_nettype wire

// File: design/ctl_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_sequencer
    import ctrl_map_pkg::*;
    import ctrl_settings_pkg::*;
(
    input  wire                   CLK,
    input  wire                   rst_n,
    input  wire                   thermo,
    input  wire                   stm_segment,
    input  wire                   mod_segment,
    input  wire  [15:0]           stm_cycle,
    input  wire  [BUS_DATA_W-1:0] dout,
    output logic                  we,
    output logic [BUS_ADDR_W-1:0] addr,
    output logic [BUS_DATA_W-1:0] din,
    fetch_if.sequencer            fetch,
    output logic                  force_fan,
    output logic [3:0]            gpio_in
);

    typedef enum logic [4:0] {
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_WAIT_0,
        ST_WAIT_1,
        ST_POLL_STATUS,
        ST_POLL_FLAG,
        ST_SIL_FLAG,
        ST_SIL_RATE_INT,
        ST_SIL_RATE_PHASE,
        ST_SIL_STEPS_INT,
        ST_SIL_STEPS_PHASE,
        ST_SYNC_0,
        ST_SYNC_1,
        ST_SYNC_2,
        ST_SYNC_3,
        ST_FLAG_WRITE,
        ST_STATUS_WRITE,
        ST_FLAG_READ
    } state_e;

    state_e                  state;
    state_e                  rd_next;
    field_e                  rd_field;
    group_e                  active_group;
    logic [BUS_ADDR_W-1:0]   rd_addr;
    logic [BUS_DATA_W-1:0]   flag_word;
    logic [BUS_DATA_W-1:0]   status_word;
    logic                    flag_rd;
    logic [READ_LATENCY-1:0] flag_pipe;

    always_comb begin
        status_word = '0;
        status_word[STATE_BIT_THERMO] = thermo;
        status_word[STATE_BIT_MOD_SEGMENT] = mod_segment;
        status_word[STATE_BIT_STM_SEGMENT] = stm_segment;
        status_word[STATE_BIT_STM_CYCLE_ZERO] = (stm_cycle == 16'd0);
    end

    assign force_fan  = flag_word[FLAG_BIT_FORCE_FAN];
    assign gpio_in[0] = flag_word[FLAG_BIT_GPIO_IN_0];
    assign gpio_in[1] = flag_word[FLAG_BIT_GPIO_IN_1];
    assign gpio_in[2] = flag_word[FLAG_BIT_GPIO_IN_2];
    assign gpio_in[3] = flag_word[FLAG_BIT_GPIO_IN_3];

    // Address, tag and successor of each settings read state.
    always_comb begin
        rd_field = FIELD_NONE;
        rd_addr  = ADDR_SILENCER_FLAG;
        rd_next  = ST_FLAG_WRITE;
        case (state)
            ST_SIL_FLAG: begin
                rd_field = FIELD_SILENCER_FLAG;
                rd_addr  = ADDR_SILENCER_FLAG;
                rd_next  = ST_SIL_RATE_INT;
            end
            ST_SIL_RATE_INT: begin
                rd_field = FIELD_UPDATE_RATE_INTENSITY;
                rd_addr  = ADDR_SILENCER_UPDATE_RATE_INTENSITY;
                rd_next  = ST_SIL_RATE_PHASE;
            end
            ST_SIL_RATE_PHASE: begin
                rd_field = FIELD_UPDATE_RATE_PHASE;
                rd_addr  = ADDR_SILENCER_UPDATE_RATE_PHASE;
                rd_next  = ST_SIL_STEPS_INT;
            end
            ST_SIL_STEPS_INT: begin
                rd_field = FIELD_COMPLETION_STEPS_INTENSITY;
                rd_addr  = ADDR_SILENCER_COMPLETION_STEPS_INTENSITY;
                rd_next  = ST_SIL_STEPS_PHASE;
            end
            ST_SIL_STEPS_PHASE: begin
                rd_field = FIELD_COMPLETION_STEPS_PHASE;
                rd_addr  = ADDR_SILENCER_COMPLETION_STEPS_PHASE;
            end
            ST_SYNC_0: begin
                rd_field = SYNC_WORD_0;
                rd_addr  = ADDR_SYNC_TIME_0;
                rd_next  = ST_SYNC_1;
            end
            ST_SYNC_1: begin
                rd_field = SYNC_WORD_1;
                rd_addr  = ADDR_SYNC_TIME_1;
                rd_next  = ST_SYNC_2;
            end
            ST_SYNC_2: begin
                rd_field = SYNC_WORD_2;
                rd_addr  = ADDR_SYNC_TIME_2;
                rd_next  = ST_SYNC_3;
            end
            ST_SYNC_3: begin
                rd_field = SYNC_WORD_3;
                rd_addr  = ADDR_SYNC_TIME_3;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state        <= ST_VER_MINOR;
            we           <= 1'b0;
            addr         <= '0;
            flag_rd      <= 1'b0;
            flag_pipe    <= '0;
            flag_word    <= '0;
            active_group <= GROUP_NONE;
            fetch.issue  <= 1'b0;
            fetch.commit <= 1'b0;
        end else begin
            flag_rd      <= 1'b0;
            fetch.issue  <= 1'b0;
            fetch.commit <= 1'b0;

            // Track each flag read until its data reaches dout.
            flag_pipe[0] <= flag_rd;
            for (int i = 1; i < READ_LATENCY; i++) begin
                flag_pipe[i] <= flag_pipe[i-1];
            end
            if (flag_pipe[READ_LATENCY-1]) begin
                flag_word <= dout;
            end

            case (state)
                ST_VER_MINOR: begin
                    we    <= 1'b1;
                    addr  <= ADDR_VERSION_NUM_MINOR;
                    din   <= BUS_DATA_W'(VERSION_MINOR);
                    state <= ST_VER_MAJOR;
                end
                ST_VER_MAJOR: begin
                    we    <= 1'b1;
                    addr  <= ADDR_VERSION_NUM_MAJOR;
                    din   <= BUS_DATA_W'(VERSION_MAJOR);
                    state <= ST_WAIT_0;
                end
                ST_WAIT_0: begin
                    we    <= 1'b0;
                    state <= ST_WAIT_1;
                end
                ST_WAIT_1: begin
                    we    <= 1'b0;
                    state <= ST_POLL_STATUS;
                end
                ST_POLL_STATUS: begin
                    we   <= 1'b1;
                    addr <= ADDR_FPGA_STATE;
                    din  <= status_word;
                    // Flag reads still in flight predate the write-back, drop them.
                    if (flag_word[FLAG_BIT_SILENCER_SET]) begin
                        flag_word[FLAG_BIT_SILENCER_SET] <= 1'b0;
                        flag_pipe    <= '0;
                        active_group <= GROUP_SILENCER;
                        state        <= ST_SIL_FLAG;
                    end else if (flag_word[FLAG_BIT_SYNC_SET]) begin
                        flag_word[FLAG_BIT_SYNC_SET] <= 1'b0;
                        flag_pipe    <= '0;
                        active_group <= GROUP_SYNC;
                        state        <= ST_SYNC_0;
                    end else begin
                        state <= ST_POLL_FLAG;
                    end
                end
                ST_POLL_FLAG, ST_FLAG_READ: begin
                    we      <= 1'b0;
                    addr    <= ADDR_CTL_FLAG;
                    flag_rd <= 1'b1;
                    state   <= ST_POLL_STATUS;
                end
                ST_SIL_FLAG, ST_SIL_RATE_INT, ST_SIL_RATE_PHASE, ST_SIL_STEPS_INT,
                ST_SIL_STEPS_PHASE, ST_SYNC_0, ST_SYNC_1, ST_SYNC_2, ST_SYNC_3: begin
                    we          <= 1'b0;
                    addr        <= rd_addr;
                    fetch.issue <= 1'b1;
                    fetch.field <= rd_field;
                    state       <= rd_next;
                end
                ST_FLAG_WRITE: begin
                    we           <= 1'b1;
                    addr         <= ADDR_CTL_FLAG;
                    din          <= flag_word;
                    fetch.commit <= 1'b1;
                    fetch.group  <= active_group;
                    state        <= ST_STATUS_WRITE;
                end
                ST_STATUS_WRITE: begin
                    we    <= 1'b1;
                    addr  <= ADDR_FPGA_STATE;
                    din   <= status_word;
                    state <= ST_FLAG_READ;
                end
                default: begin
                    we    <= 1'b0;
                    state <= ST_POLL_STATUS;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/ctrl_map_pkg.sv
`default_nettype none

package ctrl_map_pkg;

    // RAM bus geometry.
    localparam int BUS_ADDR_W = 8;
    localparam int BUS_DATA_W = 16;

    // Cycles from an address on addr to its data on dout.
    localparam int READ_LATENCY = 2;

    // Control RAM address map.
    localparam logic [BUS_ADDR_W-1:0] ADDR_CTL_FLAG                           = 8'h00;
    localparam logic [BUS_ADDR_W-1:0] ADDR_FPGA_STATE                         = 8'h01;
    localparam logic [BUS_ADDR_W-1:0] ADDR_VERSION_NUM_MAJOR                  = 8'h02;
    localparam logic [BUS_ADDR_W-1:0] ADDR_VERSION_NUM_MINOR                  = 8'h03;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SYNC_TIME_0                        = 8'h10;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SYNC_TIME_1                        = 8'h11;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SYNC_TIME_2                        = 8'h12;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SYNC_TIME_3                        = 8'h13;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SILENCER_FLAG                      = 8'h60;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SILENCER_UPDATE_RATE_INTENSITY     = 8'h61;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SILENCER_UPDATE_RATE_PHASE         = 8'h62;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SILENCER_COMPLETION_STEPS_INTENSITY = 8'h63;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SILENCER_COMPLETION_STEPS_PHASE    = 8'h64;

    // Bit positions in the control-flag word.
    localparam int FLAG_BIT_SILENCER_SET = 2;
    localparam int FLAG_BIT_GPIO_IN_0    = 4;
    localparam int FLAG_BIT_GPIO_IN_1    = 5;
    localparam int FLAG_BIT_GPIO_IN_2    = 6;
    localparam int FLAG_BIT_GPIO_IN_3    = 7;
    localparam int FLAG_BIT_SYNC_SET     = 8;
    localparam int FLAG_BIT_FORCE_FAN    = 13;

    // Firmware version.
    localparam logic [7:0] VERSION_MINOR = 8'h01;
    localparam logic [7:0] VERSION_MAJOR = 8'h0a;

    // Bit positions in the status word, all other bits read as zero.
    localparam int STATE_BIT_THERMO         = 0;
    localparam int STATE_BIT_MOD_SEGMENT    = 1;
    localparam int STATE_BIT_STM_SEGMENT    = 2;
    localparam int STATE_BIT_STM_CYCLE_ZERO = 3;

endpackage

`default_nettype wire

// File: design/ctrl_settings_pkg.sv
`default_nettype none

package ctrl_settings_pkg;

    // Silencer group, one byte per field.
    typedef struct packed {
        logic [7:0] flag;
        logic [7:0] update_rate_intensity;
        logic [7:0] update_rate_phase;
        logic [7:0] completion_steps_intensity;
        logic [7:0] completion_steps_phase;
    } silencer_settings_t;

    // Sync group, read as four 16-bit words.
    typedef struct packed {
        logic [63:0] ecat_sync_time;
    } sync_settings_t;

    localparam silencer_settings_t SILENCER_DEFAULT = '{
        flag:                       8'd0,
        update_rate_intensity:      8'd1,
        update_rate_phase:          8'd1,
        completion_steps_intensity: 8'd10,
        completion_steps_phase:     8'd40
    };

    localparam sync_settings_t SYNC_DEFAULT = '{
        ecat_sync_time: 64'd0
    };

    // Destination of one settings read.
    typedef enum logic [3:0] {
        FIELD_NONE,
        FIELD_SILENCER_FLAG,
        FIELD_UPDATE_RATE_INTENSITY,
        FIELD_UPDATE_RATE_PHASE,
        FIELD_COMPLETION_STEPS_INTENSITY,
        FIELD_COMPLETION_STEPS_PHASE,
        SYNC_WORD_0,
        SYNC_WORD_1,
        SYNC_WORD_2,
        SYNC_WORD_3
    } field_e;

    // Settings group finished by a commit.
    typedef enum logic [1:0] {
        GROUP_NONE,
        GROUP_SILENCER,
        GROUP_SYNC
    } group_e;

endpackage

`default_nettype wire

// File: design/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

// Read tags and commit tokens, sequencer to loader.
interface fetch_if
    import ctrl_settings_pkg::*;
();

    logic   issue;
    field_e field;
    logic   commit;
    group_e group;

    modport sequencer (
        output issue,
        output field,
        output commit,
        output group
    );

    modport loader (
        input issue,
        input field,
        input commit,
        input group
    );

endinterface

`default_nettype wire

// File: design/settings_loader.sv
`timescale 1ns/1ps
`default_nettype none

module settings_loader
    import ctrl_map_pkg::*;
    import ctrl_settings_pkg::*;
(
    input  wire                   CLK,
    input  wire                   rst_n,
    input  wire  [BUS_DATA_W-1:0] dout,
    fetch_if.loader               fetch,
    output silencer_settings_t    silencer_settings,
    output logic                  silencer_update,
    output sync_settings_t        sync_settings,
    output logic                  sync_update
);

    // Tags and tokens ride along with the read latency of the RAM.
    field_e field_dly [READ_LATENCY];
    group_e group_dly [READ_LATENCY];

    field_e field_out;
    group_e group_out;

    assign field_out = field_dly[READ_LATENCY-1];
    assign group_out = group_dly[READ_LATENCY-1];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < READ_LATENCY; i++) begin
                field_dly[i] <= FIELD_NONE;
                group_dly[i] <= GROUP_NONE;
            end
        end else begin
            field_dly[0] <= fetch.issue ? fetch.field : FIELD_NONE;
            group_dly[0] <= fetch.commit ? fetch.group : GROUP_NONE;
            for (int i = 1; i < READ_LATENCY; i++) begin
                field_dly[i] <= field_dly[i-1];
                group_dly[i] <= group_dly[i-1];
            end
        end
    end

    // Tag at the end of the line matches the word on dout.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            silencer_settings <= SILENCER_DEFAULT;
            sync_settings     <= SYNC_DEFAULT;
        end else begin
            case (field_out)
                FIELD_SILENCER_FLAG: begin
                    silencer_settings.flag <= dout[7:0];
                end
                FIELD_UPDATE_RATE_INTENSITY: begin
                    silencer_settings.update_rate_intensity <= dout[7:0];
                end
                FIELD_UPDATE_RATE_PHASE: begin
                    silencer_settings.update_rate_phase <= dout[7:0];
                end
                FIELD_COMPLETION_STEPS_INTENSITY: begin
                    silencer_settings.completion_steps_intensity <= dout[7:0];
                end
                FIELD_COMPLETION_STEPS_PHASE: begin
                    silencer_settings.completion_steps_phase <= dout[7:0];
                end
                SYNC_WORD_0: begin
                    sync_settings.ecat_sync_time[15:0] <= dout;
                end
                SYNC_WORD_1: begin
                    sync_settings.ecat_sync_time[31:16] <= dout;
                end
                SYNC_WORD_2: begin
                    sync_settings.ecat_sync_time[47:32] <= dout;
                end
                SYNC_WORD_3: begin
                    sync_settings.ecat_sync_time[63:48] <= dout;
                end
                default: ;
            endcase
        end
    end

    // Token leaves one cycle after the group's last field is stored.
    assign silencer_update = (group_out == GROUP_SILENCER);
    assign sync_update     = (group_out == GROUP_SYNC);

endmodule

`default_nettype wire

// File: verification/ctrl_ram_model.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral control RAM shared between host and controller.
module ctrl_ram_model
    import ctrl_map_pkg::*;
(
    input  wire                   CLK,
    input  wire                   we,
    input  wire  [BUS_ADDR_W-1:0] addr,
    input  wire  [BUS_DATA_W-1:0] din,
    output logic [BUS_DATA_W-1:0] dout
);

    localparam int DEPTH = 1 << BUS_ADDR_W;

    logic [BUS_DATA_W-1:0] mem     [DEPTH];
    logic [BUS_DATA_W-1:0] rd_pipe [READ_LATENCY];

    // Each word starts as its own address in both bytes.
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= {8'(i), 8'(i)};
        end
        for (int i = 0; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= '0;
        end
    end

    always @(posedge CLK) begin
        if (we) begin
            mem[addr] <= din;
        end
        rd_pipe[0] <= mem[addr];
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign dout = rd_pipe[READ_LATENCY-1];

    // Host side access takes effect at the end of the time step.
    task automatic poke(input logic [BUS_ADDR_W-1:0] a, input logic [BUS_DATA_W-1:0] d);
        mem[a] <= d;
    endtask

    function automatic logic [BUS_DATA_W-1:0] peek(input logic [BUS_ADDR_W-1:0] a);
        return mem[a];
    endfunction

endmodule

`default_nettype wire

// File: verification/tb_array_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_array_ctl
    import ctrl_map_pkg::*;
    import ctrl_settings_pkg::*;
();

    localparam int NUM_ROWS    = 5;
    localparam int CYCLE_LIMIT = NUM_ROWS * 200;
    localparam int ROW_WAIT    = 100;
    localparam int SETTLE      = 20;

    typedef struct {
        string            name;
        logic [15:0]      flag;
        logic             thermo;
        logic             mod_segment;
        logic             stm_segment;
        logic [15:0]      stm_cycle;
        int               exp_sil;
        int               exp_sync;
        logic             exp_fan;
        logic [3:0]       exp_gpio;
        logic [15:0]      exp_status;
        logic [4:0][15:0] sil_words;
        logic [3:0][15:0] sync_words;
    } row_t;

    logic                  CLK;
    logic                  rst_n;
    logic                  we;
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] din;
    logic [BUS_DATA_W-1:0] dout;
    logic                  thermo;
    logic                  stm_segment;
    logic                  mod_segment;
    logic [15:0]           stm_cycle;
    silencer_settings_t    silencer_settings;
    logic                  silencer_update;
    sync_settings_t        sync_settings;
    logic                  sync_update;
    logic                  force_fan;
    logic [3:0]            gpio_in;

    row_t               rows [NUM_ROWS];
    int                 seed = 32'h518d;
    int                 errors = 0;
    int                 cycles = 0;
    int                 sil_total = 0;
    int                 sync_total = 0;
    int                 sil_at = 0;
    int                 sync_at = 0;
    silencer_settings_t sil_cap;
    sync_settings_t     sync_cap;

    array_ctl_top u_array_ctl_top (
        .CLK               (CLK),
        .rst_n             (rst_n),
        .we                (we),
        .addr              (addr),
        .din               (din),
        .dout              (dout),
        .thermo            (thermo),
        .stm_segment       (stm_segment),
        .mod_segment       (mod_segment),
        .stm_cycle         (stm_cycle),
        .silencer_settings (silencer_settings),
        .silencer_update   (silencer_update),
        .sync_settings     (sync_settings),
        .sync_update       (sync_update),
        .force_fan         (force_fan),
        .gpio_in           (gpio_in)
    );

    ctrl_ram_model u_ram (
        .CLK  (CLK),
        .we   (we),
        .addr (addr),
        .din  (din),
        .dout (dout)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped, timed out after %0d cycles.", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Count update pulses and keep the settings seen on the latest one.
    always @(posedge CLK) begin
        if (rst_n && silencer_update) begin
            sil_total <= sil_total + 1;
            sil_cap   <= silencer_settings;
            sil_at    <= cycles;
        end
        if (rst_n && sync_update) begin
            sync_total <= sync_total + 1;
            sync_cap   <= sync_settings;
            sync_at    <= cycles;
        end
    end

    task automatic check(input string test, input string what,
                         input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
        end
    endtask

    task automatic set_row(input int idx, input string name, input logic [15:0] flag,
                           input logic th, input logic mseg, input logic sseg,
                           input logic [15:0] cyc, input int exp_sil, input int exp_sync,
                           input logic fan, input logic [3:0] gpio,
                           input logic [15:0] status);
        rows[idx].name        = name;
        rows[idx].flag        = flag;
        rows[idx].thermo      = th;
        rows[idx].mod_segment = mseg;
        rows[idx].stm_segment = sseg;
        rows[idx].stm_cycle   = cyc;
        rows[idx].exp_sil     = exp_sil;
        rows[idx].exp_sync    = exp_sync;
        rows[idx].exp_fan     = fan;
        rows[idx].exp_gpio    = gpio;
        rows[idx].exp_status  = status;
        for (int k = 0; k < 5; k++) begin
            rows[idx].sil_words[k] = 16'($random(seed));
        end
        for (int k = 0; k < 4; k++) begin
            rows[idx].sync_words[k] = 16'($random(seed));
        end
    endtask

    // Flag bit 2 sets silencer, 4 to 7 are gpio, 8 sets sync and 13 forces the fan.
    // Status word bit 0 is thermo, 1 mod segment, 2 stm segment, 3 a zero stm_cycle.
    task automatic build_table();
        //         name                    flag      th    mod   stm   stm_cycle
        //      sil sync fan  gpio     status
        set_row(0, "status_cycle_zero",    16'h0050, 1'b1, 1'b0, 1'b1, 16'h0000,
                0,  0,   1'b0, 4'b0101, 16'h000d);
        set_row(1, "status_cycle_nonzero", 16'h2080, 1'b0, 1'b1, 1'b0, 16'h03e8,
                0,  0,   1'b1, 4'b1000, 16'h0002);
        set_row(2, "silencer_set",         16'h0024, 1'b1, 1'b1, 1'b0, 16'h0001,
                1,  0,   1'b0, 4'b0010, 16'h0003);
        set_row(3, "sync_set",             16'h2100, 1'b0, 1'b0, 1'b1, 16'h0000,
                0,  1,   1'b1, 4'b0000, 16'h000c);
        set_row(4, "both_set",             16'h21f4, 1'b1, 1'b1, 1'b1, 16'h0100,
                1,  1,   1'b1, 4'b1111, 16'h0007);
    endtask

    task automatic check_reset_state();
        repeat (12) begin
            @(posedge CLK);
            check("reset", "silencer_update", 64'(1'b0), 64'(silencer_update));
            check("reset", "sync_update", 64'(1'b0), 64'(sync_update));
            check("reset", "silencer settings", 64'(SILENCER_DEFAULT), 64'(silencer_settings));
            check("reset", "sync settings", 64'(SYNC_DEFAULT), 64'(sync_settings));
        end
        check("reset", "version minor", 64'(VERSION_MINOR), 64'(u_ram.peek(ADDR_VERSION_NUM_MINOR)));
        check("reset", "version major", 64'(VERSION_MAJOR), 64'(u_ram.peek(ADDR_VERSION_NUM_MAJOR)));
    endtask

    task automatic load_row(input int r);
        @(posedge CLK);
        u_ram.poke(ADDR_SILENCER_FLAG, rows[r].sil_words[0]);
        u_ram.poke(ADDR_SILENCER_UPDATE_RATE_INTENSITY, rows[r].sil_words[1]);
        u_ram.poke(ADDR_SILENCER_UPDATE_RATE_PHASE, rows[r].sil_words[2]);
        u_ram.poke(ADDR_SILENCER_COMPLETION_STEPS_INTENSITY, rows[r].sil_words[3]);
        u_ram.poke(ADDR_SILENCER_COMPLETION_STEPS_PHASE, rows[r].sil_words[4]);
        u_ram.poke(ADDR_SYNC_TIME_0, rows[r].sync_words[0]);
        u_ram.poke(ADDR_SYNC_TIME_1, rows[r].sync_words[1]);
        u_ram.poke(ADDR_SYNC_TIME_2, rows[r].sync_words[2]);
        u_ram.poke(ADDR_SYNC_TIME_3, rows[r].sync_words[3]);
        u_ram.poke(ADDR_CTL_FLAG, rows[r].flag);
        thermo      <= rows[r].thermo;
        mod_segment <= rows[r].mod_segment;
        stm_segment <= rows[r].stm_segment;
        stm_cycle   <= rows[r].stm_cycle;
    endtask

    function automatic bit row_settled(input int r, input int base_sil, input int base_sync,
                                       input logic [15:0] clear_mask);
        return (sil_total - base_sil == rows[r].exp_sil)
            && (sync_total - base_sync == rows[r].exp_sync)
            && (u_ram.peek(ADDR_CTL_FLAG) == (rows[r].flag & ~clear_mask))
            && (u_ram.peek(ADDR_FPGA_STATE) == rows[r].exp_status)
            && (force_fan == rows[r].exp_fan)
            && (gpio_in == rows[r].exp_gpio);
    endfunction

    task automatic run_row(input int r);
        int          base_sil;
        int          base_sync;
        int          waited;
        bit          done;
        logic [15:0] clear_mask;
        base_sil   = sil_total;
        base_sync  = sync_total;
        clear_mask = '0;
        clear_mask[FLAG_BIT_SILENCER_SET] = 1'b1;
        clear_mask[FLAG_BIT_SYNC_SET]     = 1'b1;
        load_row(r);
        waited = 0;
        done   = 1'b0;
        while (!done && waited < ROW_WAIT) begin
            @(posedge CLK);
            waited++;
            done = row_settled(r, base_sil, base_sync, clear_mask);
        end
        if (!done) begin
            errors++;
            $display("Test %s did not settle within %0d cycles.", rows[r].name, ROW_WAIT);
        end
        // Extra cycles so that a stray second pulse is counted.
        repeat (SETTLE) @(posedge CLK);
        check(rows[r].name, "silencer pulses", 64'(rows[r].exp_sil), 64'(sil_total - base_sil));
        check(rows[r].name, "sync pulses", 64'(rows[r].exp_sync), 64'(sync_total - base_sync));
        if (rows[r].exp_sil > 0) begin
            check(rows[r].name, "flag", 64'(rows[r].sil_words[0][7:0]), 64'(sil_cap.flag));
            check(rows[r].name, "update_rate_intensity", 64'(rows[r].sil_words[1][7:0]),
                  64'(sil_cap.update_rate_intensity));
            check(rows[r].name, "update_rate_phase", 64'(rows[r].sil_words[2][7:0]),
                  64'(sil_cap.update_rate_phase));
            check(rows[r].name, "completion_steps_intensity", 64'(rows[r].sil_words[3][7:0]),
                  64'(sil_cap.completion_steps_intensity));
            check(rows[r].name, "completion_steps_phase", 64'(rows[r].sil_words[4][7:0]),
                  64'(sil_cap.completion_steps_phase));
        end
        if (rows[r].exp_sync > 0) begin
            check(rows[r].name, "ecat_sync_time",
                  {rows[r].sync_words[3], rows[r].sync_words[2],
                   rows[r].sync_words[1], rows[r].sync_words[0]},
                  sync_cap.ecat_sync_time);
        end
        if (rows[r].exp_sil > 0 && rows[r].exp_sync > 0) begin
            check(rows[r].name, "silencer pulse first", 64'(1'b1), 64'(sil_at < sync_at));
        end
        check(rows[r].name, "RAM flag word", 64'(rows[r].flag & ~clear_mask),
              64'(u_ram.peek(ADDR_CTL_FLAG)));
        check(rows[r].name, "RAM status word", 64'(rows[r].exp_status),
              64'(u_ram.peek(ADDR_FPGA_STATE)));
        check(rows[r].name, "force_fan", 64'(rows[r].exp_fan), 64'(force_fan));
        check(rows[r].name, "gpio_in", 64'(rows[r].exp_gpio), 64'(gpio_in));
    endtask

    initial begin
        rst_n       = 1'b0;
        thermo      = 1'b0;
        stm_segment = 1'b0;
        mod_segment = 1'b0;
        stm_cycle   = 16'hffff;
        build_table();
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        check_reset_state();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Checks finished with %0d error(s).", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
